//--- Bender.yml
package:
  name: afifo

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/afifo_pkg.sv
      - hdl/afifo_sync.sv
      - hdl/afifo_dpram.sv
      - hdl/afifo_wr_ctrl.sv
      - hdl/afifo_rd_ctrl.sv
      - hdl/afifo_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/afifo_checker.sv
      - dv/afifo_tb.sv

//--- afifo.f
+incdir+hdl
hdl/afifo_pkg.sv
hdl/afifo_sync.sv
hdl/afifo_dpram.sv
hdl/afifo_wr_ctrl.sv
hdl/afifo_rd_ctrl.sv
hdl/afifo_top.sv
dv/afifo_checker.sv
dv/afifo_tb.sv

//--- dv/afifo_checker.sv
`include "afifo_macros.svh"

module afifo_checker (
  input logic                    wr_clk,
  input logic                    rst,
  input logic                    wr_en,
  input logic                    full,
  input logic                    afull,
  input logic [`AFIFO_PTR_W-1:0] wr_ptr,
  input logic [`AFIFO_PTR_W-1:0] wr_gray,
  input logic                    rd_clk,
  input logic                    rd_rst,
  input logic                    rd_en,
  input logic                    empty,
  input logic                    aempty,
  input logic [`AFIFO_PTR_W-1:0] rd_ptr,
  input logic [`AFIFO_PTR_W-1:0] rd_gray
);

  // a refused write must leave the write pointer where it was
  wr_hold_a: assert property (@(posedge wr_clk) disable iff (rst !== 1'b0)
    (full && wr_en) |=> $stable(wr_ptr))
    else $error("write pointer moved on a write while full");

  rd_hold_a: assert property (@(posedge rd_clk) disable iff (rd_rst !== 1'b0)
    (empty && rd_en) |=> $stable(rd_ptr))
    else $error("read pointer moved on a read while empty");

  // the synchronizers rely on single-bit steps
  wr_gray_a: assert property (@(posedge wr_clk) disable iff (rst !== 1'b0)
    $onehot0(wr_gray ^ $past(wr_gray)))
    else $error("write Gray pointer changed more than one bit");

  rd_gray_a: assert property (@(posedge rd_clk) disable iff (rd_rst !== 1'b0)
    $onehot0(rd_gray ^ $past(rd_gray)))
    else $error("read Gray pointer changed more than one bit");

  full_afull_a: assert property (@(posedge wr_clk) disable iff (rst !== 1'b0)
    full |-> afull)
    else $error("full is high while afull is low");

  empty_aempty_a: assert property (@(posedge rd_clk) disable iff (rd_rst !== 1'b0)
    empty |-> aempty)
    else $error("empty is high while aempty is low");

endmodule

//--- dv/afifo_tb.sv
`include "afifo_macros.svh"

module afifo_tb;

  import afifo_pkg::*;

  localparam int STREAM_WORDS = 64;

  logic        wr_clk;
  logic        rd_clk;
  logic        rst;
  logic        wr_en;
  data_t       wr_data;
  logic        full;
  logic        afull;
  logic        rd_en;
  data_t       rd_data;
  logic        empty;
  logic        aempty;
  logic [31:0] lfsr;
  data_t       model[$];
  logic        rd_pend;
  data_t       rd_exp;
  int          errors;
  int          checks;
  int          tests;

  afifo_top dut0 (
    .wr_clk  (wr_clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .full    (full),
    .afull   (afull),
    .rd_clk  (rd_clk),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty),
    .aempty  (aempty)
  );

  bind afifo_top afifo_checker u_checker (
    .wr_clk  (wr_clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .full    (full),
    .afull   (afull),
    .wr_ptr  (u_wr_ctrl.wr_ptr.bin),
    .wr_gray (wr_gray),
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .rd_en   (rd_en),
    .empty   (empty),
    .aempty  (aempty),
    .rd_ptr  (u_rd_ctrl.rd_ptr.bin),
    .rd_gray (rd_gray)
  );

  initial begin
    wr_clk = 1'b0;
    forever #10 wr_clk = ~wr_clk;
  end

  // 26 against 20, so the two clocks never share an edge
  initial begin
    rd_clk = 1'b0;
    forever #13 rd_clk = ~rd_clk;
  end

  function automatic logic lfsr_step();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'hd000_0001;
    end
    return out;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic data_t next_word();
    return data_t'(take_bits(`AFIFO_DATA_W));
  endfunction

  function automatic logic in_model(input data_t w);
    foreach (model[i]) begin
      if (model[i] == w) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // one wr_clk cycle, entered and left on a rising edge
  task automatic wr_cycle(input logic en, input data_t d, output logic taken);
    wr_en   <= en;
    wr_data <= d;
    @(posedge wr_clk);
    taken = en && !full;
    if (taken) begin
      model.push_back(d);
    end
  endtask

  task automatic rd_cycle(input logic en);
    rd_en <= en;
    @(posedge rd_clk);
    // rd_data now holds the word accepted on the previous edge
    if (rd_pend) begin
      check_data(rd_data, rd_exp, "rd_data");
    end
    rd_pend = en && !empty;
    if (rd_pend) begin
      if (model.size() == 0) begin
        errors++;
        rd_pend = 1'b0;
        $display("read accepted at %0t while the reference queue was empty", $time);
      end else begin
        rd_exp = model.pop_front();
      end
    end
  endtask

  task automatic wait_not_empty(input int limit);
    int n;
    n = 0;
    while (empty !== 1'b0 && n < limit) begin
      @(posedge rd_clk);
      n++;
    end
    if (empty !== 1'b0) begin
      errors++;
      $display("timeout: empty still high after %0d rd_clk cycles", limit);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("%s finished with %0d error(s)", name, errors - err_start);
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    check_flag(full, 1'b0, "full after reset");
    check_flag(afull, 1'b0, "afull after reset");
    check_flag(empty, 1'b1, "empty after reset");
    check_flag(aempty, 1'b1, "aempty after reset");
    check_data(rd_data, '0, "rd_data after reset");
    finish_test("reset_state", e0);
  endtask

  task automatic single_word();
    int    e0;
    data_t w;
    logic  taken;
    e0 = errors;
    w  = next_word();
    @(posedge wr_clk);
    wr_cycle(1'b1, w, taken);
    check_flag(taken, 1'b1, "single write accepted");
    wr_cycle(1'b0, '0, taken);
    @(posedge rd_clk);
    wait_not_empty(8);
    rd_cycle(1'b1);
    rd_cycle(1'b0);
    check_flag(empty, 1'b1, "empty after single read");
    finish_test("single_word", e0);
  endtask

  task automatic fill_overflow();
    int    e0;
    data_t w;
    logic  taken;
    e0 = errors;
    @(posedge wr_clk);
    repeat (`AFIFO_AFULL) begin
      wr_cycle(1'b1, next_word(), taken);
    end
    wr_cycle(1'b0, '0, taken);
    check_flag(afull, 1'b1, "afull at threshold");
    repeat (`AFIFO_DEPTH - `AFIFO_AFULL) begin
      wr_cycle(1'b1, next_word(), taken);
    end
    wr_cycle(1'b0, '0, taken);
    check_flag(full, 1'b1, "full after depth writes");
    if (model.size() != `AFIFO_DEPTH) begin
      errors++;
      $display("reference queue holds %0d words after the fill, expected %0d",
               model.size(), `AFIFO_DEPTH);
    end
    // the overflow word must differ from everything stored
    w = next_word();
    while (in_model(w)) begin
      w = w + 1'b1;
    end
    wr_cycle(1'b1, w, taken);
    check_flag(taken, 1'b0, "overflow write accepted");
    wr_cycle(1'b0, '0, taken);
    finish_test("fill_overflow", e0);
  endtask

  task automatic drain_underflow();
    int    e0;
    int    n;
    e0 = errors;
    @(posedge rd_clk);
    wait_not_empty(8);
    // every entry is in use and long since visible to the read side
    check_flag(aempty, 1'b0, "aempty with a full FIFO");
    n = 0;
    while (model.size() > 0 && n < 4 * `AFIFO_DEPTH) begin
      rd_cycle(1'b1);
      n++;
    end
    rd_cycle(1'b0);
    if (model.size() != 0) begin
      errors++;
      $display("timeout: %0d words still queued after draining", model.size());
    end
    check_flag(empty, 1'b1, "empty after drain");
    check_flag(aempty, 1'b1, "aempty after drain");
    rd_cycle(1'b1);
    rd_cycle(1'b0);
    // rd_exp still holds the last word that left the queue
    check_data(rd_data, rd_exp, "rd_data after read while empty");
    finish_test("drain_underflow", e0);
  endtask

  task automatic stream_writer();
    data_t d;
    logic  taken;
    int    sent;
    int    cyc;
    sent = 0;
    cyc  = 0;
    d    = next_word();
    @(posedge wr_clk);
    while (sent < STREAM_WORDS && cyc < 1000) begin
      if (take_bits(2) == 0 || full) begin
        wr_cycle(1'b0, d, taken);
      end else begin
        wr_cycle(1'b1, d, taken);
        if (taken) begin
          sent++;
          d = next_word();
        end
      end
      cyc++;
    end
    wr_cycle(1'b0, '0, taken);
    if (sent < STREAM_WORDS) begin
      errors++;
      $display("timeout: writer got only %0d of %0d words in", sent, STREAM_WORDS);
    end
  endtask

  task automatic stream_reader();
    int got;
    int cyc;
    got = 0;
    cyc = 0;
    @(posedge rd_clk);
    while (got < STREAM_WORDS && cyc < 1000) begin
      if (take_bits(2) == 0 || empty) begin
        rd_cycle(1'b0);
      end else begin
        rd_cycle(1'b1);
      end
      if (rd_pend) begin
        got++;
      end
      cyc++;
    end
    rd_cycle(1'b0);
    if (got < STREAM_WORDS) begin
      errors++;
      $display("timeout: reader got only %0d of %0d words out", got, STREAM_WORDS);
    end
  endtask

  task automatic stream_both();
    int e0;
    e0 = errors;
    fork
      stream_writer();
      stream_reader();
    join
    if (model.size() != 0) begin
      errors++;
      $display("%0d words left in the reference queue after the stream", model.size());
    end
    check_flag(empty, 1'b1, "empty after stream");
    finish_test("stream_both", e0);
  endtask

  initial begin
    lfsr    = 32'h309e0d3f;
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_data = '0;
    rd_en   = 1'b0;
    rd_pend = 1'b0;
    rd_exp  = '0;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    repeat (2) @(posedge wr_clk);
    rst <= 1'b0;
    // rd_rst trails rst by two rd_clk edges
    repeat (6) @(posedge rd_clk);
    reset_state();
    single_word();
    fill_overflow();
    drain_underflow();
    stream_both();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- hdl/afifo_dpram.sv
`include "afifo_macros.svh"

module afifo_dpram (
  input  logic                     wr_clk,
  input  logic                     wr_accept,
  input  logic [`AFIFO_ADDR_W-1:0] wr_addr,
  input  afifo_pkg::data_t         wr_data,
  input  logic                     rd_clk,
  input  logic                     rd_rst,
  input  logic                     rd_accept,
  input  logic [`AFIFO_ADDR_W-1:0] rd_addr,
  output afifo_pkg::data_t         rd_data
);

  import afifo_pkg::*;

  data_t mem [`AFIFO_DEPTH];

  // write port lives entirely in the wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, holds its value between accepted reads
  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- hdl/afifo_macros.svh
`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// width of one data word
`define AFIFO_DATA_W 8

// number of entries, must be a power of two
`define AFIFO_DEPTH 16

// log2 of the depth
`define AFIFO_ADDR_W 4

// storage address plus one wrap bit
`define AFIFO_PTR_W (`AFIFO_ADDR_W + 1)

// afull is high when the write-side level is at or above this
`define AFIFO_AFULL 14

// aempty is high when the read-side level is at or below this
`define AFIFO_AEMPTY 2

`endif

//--- hdl/afifo_pkg.sv
package afifo_pkg;

  `include "afifo_macros.svh"

  typedef logic [`AFIFO_DATA_W-1:0] data_t;

  typedef struct packed {
    logic                     wrap;
    logic [`AFIFO_ADDR_W-1:0] addr;
  } ptr_fld_t;

  // one pointer word, read as a count or split into wrap bit and address
  typedef union packed {
    logic [`AFIFO_PTR_W-1:0] bin;
    ptr_fld_t                fld;
  } ptr_u;

  function automatic logic [`AFIFO_PTR_W-1:0] bin2gray(input logic [`AFIFO_PTR_W-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [`AFIFO_PTR_W-1:0] gray2bin(input logic [`AFIFO_PTR_W-1:0] g);
    logic [`AFIFO_PTR_W-1:0] b;
    b[`AFIFO_PTR_W-1] = g[`AFIFO_PTR_W-1];
    for (int i = `AFIFO_PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

endpackage

//--- hdl/afifo_rd_ctrl.sv
`include "afifo_macros.svh"

module afifo_rd_ctrl (
  input  logic                     rd_clk,
  input  logic                     rst,
  input  logic                     rd_en,
  input  logic [`AFIFO_PTR_W-1:0]  wr_gray_sync,
  output logic                     rd_accept,
  output logic [`AFIFO_ADDR_W-1:0] rd_addr,
  output logic [`AFIFO_PTR_W-1:0]  rd_gray,
  output logic                     rd_rst,
  output logic                     empty,
  output logic                     aempty
);

  import afifo_pkg::*;

  localparam logic [`AFIFO_PTR_W-1:0] AEMPTY_LVL = `AFIFO_AEMPTY;

  logic                    rst_meta;
  ptr_u                    rd_ptr;
  ptr_u                    rd_ptr_nxt;
  ptr_u                    wr_ptr;
  logic [`AFIFO_PTR_W-1:0] level_nxt;
  logic                    empty_nxt;
  logic                    aempty_nxt;

  // rst comes from the wr_clk domain, two flops bring it over
  always_ff @(posedge rd_clk) begin
    rst_meta <= rst;
    rd_rst   <= rst_meta;
  end

  assign rd_accept = rd_en & ~empty;
  assign rd_addr   = rd_ptr.fld.addr;

  always_comb begin
    rd_ptr_nxt.bin = rd_ptr.bin + `AFIFO_PTR_W'(rd_accept);
  end

  // write pointer as seen from this side, possibly a few writes behind
  assign wr_ptr.bin = gray2bin(wr_gray_sync);

  assign level_nxt  = wr_ptr.bin - rd_ptr_nxt.bin;
  assign empty_nxt  = rd_ptr_nxt.bin == wr_ptr.bin;
  assign aempty_nxt = level_nxt <= AEMPTY_LVL;

  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      rd_ptr.bin <= '0;
      rd_gray    <= '0;
      empty      <= 1'b1;
      aempty     <= 1'b1;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= bin2gray(rd_ptr_nxt.bin);
      empty   <= empty_nxt;
      aempty  <= aempty_nxt;
    end
  end

endmodule

//--- hdl/afifo_sync.sv
module afifo_sync #(
  parameter int WIDTH = 5
) (
  input  logic             clk,
  input  logic             clr,
  input  logic [WIDTH-1:0] gray_in,
  output logic [WIDTH-1:0] gray_out
);

  // first stage may go metastable, the second one settles it
  logic [WIDTH-1:0] meta;

  // the input is Gray coded, so a sample taken mid-change is off by
  // at most one step and never a torn multi-bit value
  always_ff @(posedge clk) begin
    if (clr) begin
      meta     <= '0;
      gray_out <= '0;
    end else begin
      meta     <= gray_in;
      gray_out <= meta;
    end
  end

endmodule

//--- hdl/afifo_top.sv
`include "afifo_macros.svh"

module afifo_top (
  input  logic             wr_clk,
  input  logic             rst,
  input  logic             wr_en,
  input  afifo_pkg::data_t wr_data,
  output logic             full,
  output logic             afull,
  input  logic             rd_clk,
  input  logic             rd_en,
  output afifo_pkg::data_t rd_data,
  output logic             empty,
  output logic             aempty
);

  import afifo_pkg::*;

  localparam int PTR_W = $bits(ptr_u);

  logic                     wr_accept;
  logic [`AFIFO_ADDR_W-1:0] wr_addr;
  logic [PTR_W-1:0]         wr_gray;
  logic [PTR_W-1:0]         wr_gray_sync;
  logic                     rd_accept;
  logic [`AFIFO_ADDR_W-1:0] rd_addr;
  logic [PTR_W-1:0]         rd_gray;
  logic [PTR_W-1:0]         rd_gray_sync;
  logic                     rd_rst;

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk       (wr_clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_accept    (wr_accept),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rst          (rst),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_accept    (rd_accept),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .rd_rst       (rd_rst),
    .empty        (empty),
    .aempty       (aempty)
  );

  afifo_dpram u_dpram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  // write pointer into the read domain
  afifo_sync #(.WIDTH(`AFIFO_PTR_W)) u_wr2rd (
    .clk      (rd_clk),
    .clr      (rd_rst),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  // read pointer into the write domain
  afifo_sync #(.WIDTH(`AFIFO_PTR_W)) u_rd2wr (
    .clk      (wr_clk),
    .clr      (rst),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

endmodule

//--- hdl/afifo_wr_ctrl.sv
`include "afifo_macros.svh"

module afifo_wr_ctrl (
  input  logic                     wr_clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  logic [`AFIFO_PTR_W-1:0]  rd_gray_sync,
  output logic                     wr_accept,
  output logic [`AFIFO_ADDR_W-1:0] wr_addr,
  output logic [`AFIFO_PTR_W-1:0]  wr_gray,
  output logic                     full,
  output logic                     afull
);

  import afifo_pkg::*;

  localparam logic [`AFIFO_PTR_W-1:0] AFULL_LVL = `AFIFO_AFULL;

  ptr_u                    wr_ptr;
  ptr_u                    wr_ptr_nxt;
  ptr_u                    rd_ptr;
  logic [`AFIFO_PTR_W-1:0] level_nxt;
  logic                    full_nxt;
  logic                    afull_nxt;

  assign wr_accept = wr_en & ~full;
  assign wr_addr   = wr_ptr.fld.addr;

  always_comb begin
    wr_ptr_nxt.bin = wr_ptr.bin + `AFIFO_PTR_W'(wr_accept);
  end

  // read pointer as seen from this side, possibly a few reads behind
  assign rd_ptr.bin = gray2bin(rd_gray_sync);

  // modulo subtraction gives the level even across a pointer wrap
  assign level_nxt = wr_ptr_nxt.bin - rd_ptr.bin;

  // same slot but one lap ahead means every entry is in use
  assign full_nxt  = (wr_ptr_nxt.fld.addr == rd_ptr.fld.addr) &&
                     (wr_ptr_nxt.fld.wrap != rd_ptr.fld.wrap);
  assign afull_nxt = level_nxt >= AFULL_LVL;

  always_ff @(posedge wr_clk) begin
    if (rst) begin
      wr_ptr.bin <= '0;
      wr_gray    <= '0;
      full       <= 1'b0;
      afull      <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= bin2gray(wr_ptr_nxt.bin);
      full    <= full_nxt;
      afull   <= afull_nxt;
    end
  end

endmodule
